/* verilog/mem_pkg.sv */
package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus and memory sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int xlen           = 32;
    localparam int xbytes         = xlen / 8;  // byte lanes per word
    localparam int ram_words      = 1024;      // 4 KiB of RAM
    localparam int ram_index_bits = 10;

    // address bit 31 picks the region
    localparam logic region_ram  = 1'b0;
    localparam logic region_mmio = 1'b1;

    // machine timer register selects, one 32-bit word each
    localparam logic [1:0] reg_mtime_lo    = 2'd0;
    localparam logic [1:0] reg_mtime_hi    = 2'd1;
    localparam logic [1:0] reg_mtimecmp_lo = 2'd2;
    localparam logic [1:0] reg_mtimecmp_hi = 2'd3;

    // arbiter FSM encodings
    localparam logic [1:0] st_wait_cmd            = 2'd0;
    localparam logic [1:0] st_wait_mem_ready      = 2'd1;
    localparam logic [1:0] st_wait_mem_read_valid = 2'd2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address word, seen as RAM or as MMIO
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef union packed {
        struct packed {
            logic                      region;
            logic [18:0]               unused;  // RAM aliases every 4 KiB
            logic [ram_index_bits-1:0] index;
            logic [1:0]                offset;
        } ram_view;
        struct packed {
            logic        region;
            logic [26:0] unused;  // timer aliases every 16 bytes
            logic [1:0]  sel;
            logic [1:0]  offset;
        } mmio_view;
    } mem_addr_u;

endpackage

/* verilog/ram_store.sv */
`timescale 1ns/1ps

module ram_store (
    input  logic                              clk,
    input  logic                              en,
    input  logic                              we,
    input  logic [mem_pkg::ram_index_bits-1:0] index,
    input  logic [mem_pkg::xlen-1:0]           wdata,
    input  logic [mem_pkg::xbytes-1:0]         wmask,
    output logic [mem_pkg::xlen-1:0]           rdata
);

    import mem_pkg::*;

    logic [xlen-1:0] mem [ram_words];

    // one port, either a masked write or a registered whole-word read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int b = 0; b < xbytes; b++) begin
                    if (wmask[b]) begin
                        mem[index][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata <= mem[index];  // shows up the cycle after en
            end
        end
    end

endmodule

/* verilog/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      en,
    input  logic                      we,
    input  logic [1:0]                sel,
    input  logic [mem_pkg::xlen-1:0]   wdata,
    input  logic [mem_pkg::xbytes-1:0] wmask,
    output logic [mem_pkg::xlen-1:0]   rdata,
    output logic                      timer_irq
);

    import mem_pkg::*;

    logic [63:0] mtime;
    logic [63:0] mtimecmp;

    // free running, software cannot write it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime <= 64'd0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare register, byte maskable halves
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtimecmp <= '1;  // all ones keeps the interrupt quiet out of reset
        end else if (en && we) begin
            for (int b = 0; b < xbytes; b++) begin
                if (wmask[b]) begin
                    if (sel == reg_mtimecmp_lo) begin
                        mtimecmp[8*b +: 8] <= wdata[8*b +: 8];
                    end else if (sel == reg_mtimecmp_hi) begin
                        mtimecmp[xlen+8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en && !we) begin
            case (sel)
                reg_mtime_lo:    rdata <= mtime[xlen-1:0];
                reg_mtime_hi:    rdata <= mtime[63:xlen];
                reg_mtimecmp_lo: rdata <= mtimecmp[xlen-1:0];
                default:         rdata <= mtimecmp[63:xlen];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);  // level, held until mtimecmp moves up
        end
    end

endmodule

/* verilog/mem_map_ctrl.sv */
`timescale 1ns/1ps

module mem_map_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      mem_start,
    input  logic                      mem_write,
    input  logic [mem_pkg::xlen-1:0]   mem_addr,
    input  logic [mem_pkg::xlen-1:0]   mem_wdata,
    input  logic [mem_pkg::xbytes-1:0] mem_sel,
    output logic                      mem_ready,
    output logic [mem_pkg::xlen-1:0]   mem_rdata,
    output logic                      mem_rdata_valid,
    output logic                      timer_irq
);

    import mem_pkg::*;

    mem_addr_u addr_u;
    logic      accept;
    logic      to_mmio;

    logic                      ram_en;
    logic [xlen-1:0]           ram_rdata;
    logic                      tmr_en;
    logic [xlen-1:0]           tmr_rdata;

    logic rd_pending;
    logic rd_mmio;  // which target owns the pending read

    assign addr_u  = mem_addr;
    assign accept  = mem_start && mem_ready;
    assign to_mmio = (addr_u.mmio_view.region == region_mmio);

    assign ram_en = accept && (addr_u.ram_view.region == region_ram);
    assign tmr_en = accept && to_mmio;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // targets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ram_store ram0 (
        .clk   (clk),
        .en    (ram_en),
        .we    (mem_write),
        .index (addr_u.ram_view.index),
        .wdata (mem_wdata),
        .wmask (mem_sel),
        .rdata (ram_rdata)
    );

    clint_timer timer0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (tmr_en),
        .we        (mem_write),
        .sel       (addr_u.mmio_view.sel),
        .wdata     (mem_wdata),
        .wmask     (mem_sel),
        .rdata     (tmr_rdata),
        .timer_irq (timer_irq)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= accept && !mem_write;  // both targets answer in one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_mmio <= to_mmio;
        end
    end

    assign mem_ready       = !rd_pending;
    assign mem_rdata_valid = rd_pending;
    assign mem_rdata       = rd_mmio ? tmr_rdata : ram_rdata;

endmodule

/* verilog/mem_interface.sv */
`timescale 1ns/1ps

module mem_interface (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      halt,

    input  logic                      ibus_cyc,
    input  logic                      ibus_stb,
    input  logic [mem_pkg::xlen-1:0]   ibus_adr,
    output logic [mem_pkg::xlen-1:0]   ibus_dat_r,
    output logic                      ibus_ack,

    input  logic                      dbus_cyc,
    input  logic                      dbus_stb,
    input  logic                      dbus_we,
    input  logic [mem_pkg::xbytes-1:0] dbus_sel,
    input  logic [mem_pkg::xlen-1:0]   dbus_adr,
    input  logic [mem_pkg::xlen-1:0]   dbus_dat_w,
    output logic [mem_pkg::xlen-1:0]   dbus_dat_r,
    output logic                      dbus_ack,

    output logic                      mem_start,
    output logic                      mem_write,
    output logic [mem_pkg::xlen-1:0]   mem_addr,
    output logic [mem_pkg::xlen-1:0]   mem_wdata,
    output logic [mem_pkg::xbytes-1:0] mem_sel,
    input  logic                      mem_ready,
    input  logic [mem_pkg::xlen-1:0]   mem_rdata,
    input  logic                      mem_rdata_valid
);

    import mem_pkg::*;

    logic [1:0] state;

    // captured requests
    logic              ireq_pend;
    logic [xlen-1:0]   ireq_adr;
    logic              dreq_pend;
    logic              dreq_we;
    logic [xlen-1:0]   dreq_adr;
    logic [xlen-1:0]   dreq_dat;
    logic [xbytes-1:0] dreq_sel;

    logic mem_accept;
    logic read_done;

    // instruction side always goes first while it is pending
    assign mem_start = !halt && (state == st_wait_mem_ready) && (ireq_pend || dreq_pend);
    assign mem_write = !ireq_pend && dreq_pend && dreq_we;
    assign mem_addr  = ireq_pend ? ireq_adr : dreq_adr;
    assign mem_wdata = dreq_dat;
    assign mem_sel   = ireq_pend ? {xbytes{1'b1}} : dreq_sel;

    assign mem_accept = mem_start && mem_ready;
    assign read_done  = !halt && (state == st_wait_mem_read_valid) && mem_rdata_valid;

    assign ibus_ack = read_done && ireq_pend;
    assign dbus_ack = (read_done && !ireq_pend && dreq_pend)
                      || (mem_accept && mem_write);  // writes ack on acceptance

    assign ibus_dat_r = mem_rdata;
    assign dbus_dat_r = mem_rdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request capture, payload only
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!halt && state == st_wait_cmd) begin
            ireq_adr <= ibus_adr;
            dreq_we  <= dbus_we;
            dreq_adr <= dbus_adr;
            dreq_dat <= dbus_dat_w;
            dreq_sel <= dbus_sel;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // arbiter FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_wait_cmd;
            ireq_pend <= 1'b0;
            dreq_pend <= 1'b0;
        end else if (!halt) begin
            case (state)
                st_wait_cmd: begin
                    ireq_pend <= ibus_cyc && ibus_stb;
                    dreq_pend <= dbus_cyc && dbus_stb;
                    if ((ibus_cyc && ibus_stb) || (dbus_cyc && dbus_stb)) begin
                        state <= st_wait_mem_ready;
                    end
                end
                st_wait_mem_ready: begin
                    if (mem_accept) begin
                        if (mem_write) begin
                            dreq_pend <= 1'b0;
                            state     <= st_wait_cmd;
                        end else begin
                            state <= st_wait_mem_read_valid;
                        end
                    end
                end
                st_wait_mem_read_valid: begin
                    if (ibus_ack) begin
                        ireq_pend <= 1'b0;
                        state     <= dreq_pend ? st_wait_mem_ready : st_wait_cmd;
                    end else if (dbus_ack) begin
                        dreq_pend <= 1'b0;
                        state     <= st_wait_cmd;
                    end
                end
                default: state <= st_wait_cmd;
            endcase
        end
    end

endmodule

/* verilog/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      halt,

    // instruction port, read only
    input  logic                      ibus_cyc,
    input  logic                      ibus_stb,
    input  logic [mem_pkg::xlen-1:0]   ibus_adr,
    output logic [mem_pkg::xlen-1:0]   ibus_dat_r,
    output logic                      ibus_ack,

    // data port
    input  logic                      dbus_cyc,
    input  logic                      dbus_stb,
    input  logic                      dbus_we,
    input  logic [mem_pkg::xbytes-1:0] dbus_sel,
    input  logic [mem_pkg::xlen-1:0]   dbus_adr,
    input  logic [mem_pkg::xlen-1:0]   dbus_dat_w,
    output logic [mem_pkg::xlen-1:0]   dbus_dat_r,
    output logic                      dbus_ack,

    output logic                      timer_irq
);

    import mem_pkg::*;

    // command link between arbiter and address decoder
    logic              mem_start;
    logic              mem_write;
    logic [xlen-1:0]   mem_addr;
    logic [xlen-1:0]   mem_wdata;
    logic [xbytes-1:0] mem_sel;
    logic              mem_ready;
    logic [xlen-1:0]   mem_rdata;
    logic              mem_rdata_valid;

    mem_interface arb0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .halt            (halt),
        .ibus_cyc        (ibus_cyc),
        .ibus_stb        (ibus_stb),
        .ibus_adr        (ibus_adr),
        .ibus_dat_r      (ibus_dat_r),
        .ibus_ack        (ibus_ack),
        .dbus_cyc        (dbus_cyc),
        .dbus_stb        (dbus_stb),
        .dbus_we         (dbus_we),
        .dbus_sel        (dbus_sel),
        .dbus_adr        (dbus_adr),
        .dbus_dat_w      (dbus_dat_w),
        .dbus_dat_r      (dbus_dat_r),
        .dbus_ack        (dbus_ack),
        .mem_start       (mem_start),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_sel         (mem_sel),
        .mem_ready       (mem_ready),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid)
    );

    mem_map_ctrl map0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_start       (mem_start),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_sel         (mem_sel),
        .mem_ready       (mem_ready),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid),
        .timer_irq       (timer_irq)
    );

endmodule

/* test/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;

    import mem_pkg::*;

    // all tests together take a few hundred cycles, so this bound is never reached when healthy
    localparam int max_cycles = 4000;
    localparam int irq_lead   = 60;  // distance from mtime to the new mtimecmp

    logic              clk;
    logic              rst_n;
    logic              halt;
    logic              ibus_cyc;
    logic              ibus_stb;
    logic [xlen-1:0]   ibus_adr;
    logic [xlen-1:0]   ibus_dat_r;
    logic              ibus_ack;
    logic              dbus_cyc;
    logic              dbus_stb;
    logic              dbus_we;
    logic [xbytes-1:0] dbus_sel;
    logic [xlen-1:0]   dbus_adr;
    logic [xlen-1:0]   dbus_dat_w;
    logic [xlen-1:0]   dbus_dat_r;
    logic              dbus_ack;
    logic              timer_irq;

    logic [7:0] ref_mem [4096];  // byte model of the RAM, aliasing every 4 KiB

    int     errors;
    int     xfers;
    int     cyc_cnt;
    integer seed;

    // what the next ack on each port has to look like
    int          i_exp_cyc;
    logic [31:0] i_exp_dat;
    string       i_name;
    int          d_exp_cyc;
    logic [31:0] d_exp_dat;
    bit          d_chk_dat;
    string       d_name;
    bit          cmp_written;
    bit          irq_hold;

    mem_subsys_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .halt       (halt),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_adr   (ibus_adr),
        .ibus_dat_r (ibus_dat_r),
        .ibus_ack   (ibus_ack),
        .dbus_cyc   (dbus_cyc),
        .dbus_stb   (dbus_stb),
        .dbus_we    (dbus_we),
        .dbus_sel   (dbus_sel),
        .dbus_adr   (dbus_adr),
        .dbus_dat_w (dbus_dat_w),
        .dbus_dat_r (dbus_dat_r),
        .dbus_ack   (dbus_ack),
        .timer_irq  (timer_irq)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reporting and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s: %s expected 0x%08h actual 0x%08h", test, what, exp, act);
        errors++;
    endtask

    task automatic report_cycle(input string test, input string what, input int exp, input int act);
        $display("Fail %s: %s expected cycle %0d actual cycle %0d", test, what, exp, act);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("error at cycle %0d: %s", cyc_cnt, msg);
        errors++;
    endtask

    function automatic logic [31:0] model_word(input logic [31:0] adr);
        logic [11:0] a;
        a = {adr[11:2], 2'b00};
        return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
    endfunction

    task automatic model_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
        logic [11:0] a;
        a = {adr[11:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                ref_mem[a + b] = dat[8*b +: 8];  // unselected lanes keep their old byte
            end
        end
    endtask

    function automatic logic [31:0] tmr_adr(input logic [1:0] sel);
        return {1'b1, 27'd0, sel, 2'b00};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone master tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_dbus(input string name, input logic we, input logic [31:0] adr,
                              input logic [31:0] dat, input logic [3:0] sel, input int exp_cyc,
                              input bit chk, input logic [31:0] exp);
        d_name     = name;
        d_exp_cyc  = exp_cyc;
        d_chk_dat  = chk && !we;
        d_exp_dat  = exp;
        dbus_cyc   <= 1'b1;
        dbus_stb   <= 1'b1;
        dbus_we    <= we;
        dbus_adr   <= adr;
        dbus_dat_w <= dat;
        dbus_sel   <= sel;
    endtask

    task automatic finish_dbus(output logic [31:0] got);
        @(posedge clk);
        while (!dbus_ack) begin
            @(posedge clk);
        end
        got = dbus_dat_r;
        dbus_cyc <= 1'b0;
        dbus_stb <= 1'b0;
        xfers++;
    endtask

    task automatic data_xfer(input string name, input logic we, input logic [31:0] adr,
                             input logic [31:0] dat, input logic [3:0] sel, input bit chk,
                             input logic [31:0] exp, output logic [31:0] got);
        @(posedge clk);
        // sampled at the next edge, then a write takes 1 more cycle and a read 2
        drive_dbus(name, we, adr, dat, sel, cyc_cnt + (we ? 2 : 3), chk, exp);
        finish_dbus(got);
    endtask

    task automatic ram_write(input string name, input logic [31:0] adr,
                             input logic [31:0] dat, input logic [3:0] sel);
        logic [31:0] got;
        model_write(adr, dat, sel);
        data_xfer(name, 1'b1, adr, dat, sel, 1'b0, 32'd0, got);
    endtask

    task automatic ram_read(input string name, input logic [31:0] adr);
        logic [31:0] got;
        data_xfer(name, 1'b0, adr, 32'd0, 4'hf, 1'b1, model_word(adr), got);
    endtask

    task automatic inst_fetch(input string name, input logic [31:0] adr);
        @(posedge clk);
        i_name    = name;
        i_exp_cyc = cyc_cnt + 3;
        i_exp_dat = model_word(adr);
        ibus_cyc <= 1'b1;
        ibus_stb <= 1'b1;
        ibus_adr <= adr;
        @(posedge clk);
        while (!ibus_ack) begin
            @(posedge clk);
        end
        ibus_cyc <= 1'b0;
        ibus_stb <= 1'b0;
        xfers++;
    endtask

    // both ports raise stb at the same edge, the instruction is served first
    task automatic dual_request(input string name, input logic [31:0] iadr, input logic d_we,
                                input logic [31:0] dadr, input logic [31:0] ddat);
        bit i_done;
        bit d_done;
        @(posedge clk);
        i_name    = name;
        i_exp_cyc = cyc_cnt + 3;
        i_exp_dat = model_word(iadr);
        ibus_cyc <= 1'b1;
        ibus_stb <= 1'b1;
        ibus_adr <= iadr;
        drive_dbus(name, d_we, dadr, ddat, 4'hf, cyc_cnt + (d_we ? 4 : 5), 1'b1, model_word(dadr));
        if (d_we) begin
            model_write(dadr, ddat, 4'hf);
        end
        i_done = 1'b0;
        d_done = 1'b0;
        while (!(i_done && d_done)) begin
            @(posedge clk);
            if (ibus_ack) begin
                ibus_cyc <= 1'b0;
                ibus_stb <= 1'b0;
                i_done = 1'b1;
                xfers++;
            end
            if (dbus_ack) begin
                dbus_cyc <= 1'b0;
                dbus_stb <= 1'b0;
                d_done = 1'b1;
                xfers++;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_ibus_proto: assert property (@(posedge clk) disable iff (!rst_n)
        ibus_ack |-> (ibus_cyc && ibus_stb))
        else report_problem("ibus_ack came without an active ibus request");

    a_dbus_proto: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_ack |-> (dbus_cyc && dbus_stb))
        else report_problem("dbus_ack came without an active dbus request");

    a_ibus_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        ibus_ack |-> (cyc_cnt == i_exp_cyc))
        else report_cycle(i_name, "ibus_ack", i_exp_cyc, $sampled(cyc_cnt));

    a_ibus_dat: assert property (@(posedge clk) disable iff (!rst_n)
        ibus_ack |-> (ibus_dat_r == i_exp_dat))
        else report_mismatch(i_name, "ibus_dat_r", i_exp_dat, $sampled(ibus_dat_r));

    a_dbus_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_ack |-> (cyc_cnt == d_exp_cyc))
        else report_cycle(d_name, "dbus_ack", d_exp_cyc, $sampled(cyc_cnt));

    a_dbus_dat: assert property (@(posedge clk) disable iff (!rst_n)
        (dbus_ack && d_chk_dat) |-> (dbus_dat_r == d_exp_dat))
        else report_mismatch(d_name, "dbus_dat_r", d_exp_dat, $sampled(dbus_dat_r));

    a_irq_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !cmp_written |-> !timer_irq)
        else report_mismatch("timer_idle", "timer_irq", 32'd0, 32'd1);

    a_irq_hold: assert property (@(posedge clk) disable iff (!rst_n)
        irq_hold |-> timer_irq)
        else report_mismatch("timer_hold", "timer_irq", 32'd1, 32'd0);

    initial begin
        wait (cyc_cnt >= max_cycles);
        $display("timeout after %0d cycles, a request was never acknowledged", cyc_cnt);
        $display("transfers %0d, errors %0d", xfers, errors);
        $display("Result: FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] addrs [32];
        logic [3:0]  sels [4];
        logic [31:0] rd;
        logic [31:0] t0;
        logic [31:0] t1;
        logic [31:0] w;
        int          t_cyc;

        seed        = 30;
        errors      = 0;
        xfers       = 0;
        cyc_cnt     = 0;
        cmp_written = 1'b0;
        irq_hold    = 1'b0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        halt        = 1'b0;
        ibus_cyc    = 1'b0;
        ibus_stb    = 1'b0;
        ibus_adr    = '0;
        dbus_cyc    = 1'b0;
        dbus_stb    = 1'b0;
        dbus_we     = 1'b0;
        dbus_sel    = '0;
        dbus_adr    = '0;
        dbus_dat_w  = '0;
        sels        = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < 32; i++) begin
            addrs[i] = $random(seed) & 32'h7fff_fffc;  // region bit clear, upper bits alias
            ram_write("wr_rd", addrs[i], $random(seed), 4'hf);
        end
        for (int i = 0; i < 32; i++) begin
            ram_read("wr_rd", addrs[i]);
        end

        for (int i = 0; i < 4; i++) begin
            ram_write("byte_sel", addrs[i], $random(seed), sels[i]);
            ram_read("byte_sel", addrs[i]);
        end

        ram_write("fetch", 32'h0000_0100, $random(seed), 4'hf);
        inst_fetch("fetch", 32'h0000_0100);
        inst_fetch("fetch_alias", 32'h0000_1100);
        inst_fetch("fetch_alias", 32'h0004_3100);
        inst_fetch("fetch", addrs[12]);

        dual_request("dual_rd", addrs[5], 1'b0, addrs[6], 32'd0);
        dual_request("dual_wr", addrs[7], 1'b1, addrs[8], $random(seed));
        ram_read("dual_wr", addrs[8]);

        // timer, mtime first
        data_xfer("mtime", 1'b0, tmr_adr(reg_mtime_lo), 32'd0, 4'hf, 1'b0, 32'd0, t0);
        data_xfer("mtime", 1'b0, tmr_adr(reg_mtime_lo), 32'd0, 4'hf, 1'b0, 32'd0, t1);
        assert (t1 > t0) else report_mismatch("mtime_order", "mtime_lo at least", t0 + 1, t1);

        cmp_written = 1'b1;
        w = $random(seed);
        data_xfer("cmp_lo", 1'b1, tmr_adr(reg_mtimecmp_lo), w, 4'b0101, 1'b0, 32'd0, rd);
        data_xfer("cmp_lo", 1'b0, tmr_adr(reg_mtimecmp_lo), 32'd0, 4'hf, 1'b1,
                  (w & 32'h00ff_00ff) | 32'hff00_ff00, rd);
        w = $random(seed) | 32'h8000_0000;  // top byte stays high so no interrupt yet
        data_xfer("cmp_hi", 1'b1, tmr_adr(reg_mtimecmp_hi), w, 4'b1010, 1'b0, 32'd0, rd);
        data_xfer("cmp_hi", 1'b0, tmr_adr(reg_mtimecmp_hi) + 32'h40, 32'd0, 4'hf, 1'b1,
                  (w & 32'hff00_ff00) | 32'h00ff_00ff, rd);

        data_xfer("irq", 1'b0, tmr_adr(reg_mtime_lo), 32'd0, 4'hf, 1'b0, 32'd0, t0);
        t_cyc = cyc_cnt;
        data_xfer("irq", 1'b1, tmr_adr(reg_mtimecmp_lo), t0 + irq_lead, 4'hf, 1'b0, 32'd0, rd);
        data_xfer("irq", 1'b1, tmr_adr(reg_mtimecmp_hi), 32'd0, 4'hf, 1'b0, 32'd0, rd);
        repeat (2) @(posedge clk);
        assert (!timer_irq) else report_mismatch("irq_low", "timer_irq", 32'd0, 32'd1);
        while (!timer_irq && (cyc_cnt - t_cyc) <= irq_lead + 3) begin
            @(posedge clk);
        end
        assert (timer_irq) else report_mismatch("irq_rise", "timer_irq", 32'd1, 32'd0);
        irq_hold = 1'b1;
        repeat (20) @(posedge clk);

        // halt while idle, then a data read that has to wait it out
        @(posedge clk);
        halt <= 1'b1;
        @(posedge clk);
        drive_dbus("halt", 1'b0, addrs[10], 32'd0, 4'hf, -1, 1'b1, model_word(addrs[10]));
        repeat (10) @(posedge clk);
        halt <= 1'b0;
        d_exp_cyc = cyc_cnt + 3;
        finish_dbus(rd);

        repeat (4) @(posedge clk);
        $display("transfers %0d, errors %0d", xfers, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
verilog/mem_pkg.sv
verilog/ram_store.sv
verilog/clint_timer.sv
verilog/mem_map_ctrl.sv
verilog/mem_interface.sv
verilog/mem_subsys_top.sv
test/tb_mem_subsys.sv
